// ==== vlog.f ====
+incdir+logic
logic/alu_pkg.sv
logic/issue_if.sv
logic/result_if.sv
logic/op_decode.sv
logic/shift_add_multiplier.sv
logic/alu_execute.sv
logic/result_stage.sv
logic/alu_top.sv
testbench/tb_alu_top.sv

// ==== testbench/tb_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module tb_alu_top;

  localparam int RESET_CYCLES = 4;
  localparam int N_DIR = 18;
  localparam int N_RAND = 12;
  // Two spare slots cover the idle check and the stray issue test
  localparam int TIMEOUT_CYCLES = (N_DIR + N_RAND + 2) * (`ALU_MUL_STEPS + 8) + RESET_CYCLES;

  // One table row
  typedef struct packed {
    logic [31:0] instr;
    alu_pkg::data_t a;
    alu_pkg::data_t b;
    alu_pkg::data_t res;
    alu_pkg::reg_idx_t rd;
    logic zero;
    logic illegal;
    logic fixed_lat;
  } vector_t;

  logic clk = 1'b0;
  logic rst_n;
  logic issue;
  logic [31:0] instr;
  alu_pkg::data_t operand_a;
  alu_pkg::data_t operand_b;
  logic busy;
  logic done;
  alu_pkg::data_t result;
  alu_pkg::reg_idx_t rd;
  logic zero;
  logic illegal;

  vector_t vectors[$];
  int cycle_count = 0;
  int test_errs;
  int tests_run = 0;
  int tests_failed = 0;
  integer seed;
  alu_pkg::data_t ra;
  alu_pkg::data_t rb;
  alu_pkg::reg_idx_t rr;

  alu_top i_alu_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue),
    .instr     (instr),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .busy      (busy),
    .done      (done),
    .result    (result),
    .rd        (rd),
    .zero      (zero),
    .illegal   (illegal)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: done never arrived");
      $display("Test FAILED");
      $finish;
    end
  end

  // rs1 and rs2 fields are don't-care here
  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [6:0] opc, input alu_pkg::reg_idx_t rd_i);
    return {f7, 5'd2, 5'd1, f3, rd_i, opc};
  endfunction

  task automatic add_vector(input logic [6:0] f7, input logic [2:0] f3, input logic [6:0] opc,
                            input alu_pkg::reg_idx_t rd_i, input alu_pkg::data_t a,
                            input alu_pkg::data_t b, input alu_pkg::data_t res,
                            input logic z, input logic ill);
    vector_t v;
    begin
      v.instr = rtype_word(f7, f3, opc, rd_i);
      v.a = a;
      v.b = b;
      v.res = res;
      v.rd = rd_i;
      v.zero = z;
      v.illegal = ill;
      // Only a legal multiply has a variable latency
      v.fixed_lat = !(opc == `ALU_OPCODE_OP && f3 == `ALU_F3_ADD && f7 == `ALU_F7_MULDIV);
      vectors.push_back(v);
    end
  endtask

  task automatic check_data(input string name, input alu_pkg::data_t exp,
                            input alu_pkg::data_t act);
    if (exp !== act)
    begin
      $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_idx(input string name, input alu_pkg::reg_idx_t exp,
                           input alu_pkg::reg_idx_t act);
    if (exp !== act)
    begin
      $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errs == 0)
      $display("%s: pass", name);
    else
    begin
      tests_failed++;
      $display("%s: %0d mismatches", name, test_errs);
    end
  endtask

  // Issue one row, wait for done, compare
  task automatic run_vector(input int idx);
    vector_t v;
    int cycles;
    begin
      v = vectors[idx];
      test_errs = 0;
      cycles = 0;
      @(negedge clk);
      while (busy)
        @(negedge clk);
      issue = 1'b1;
      instr = v.instr;
      operand_a = v.a;
      operand_b = v.b;
      do
      begin
        @(posedge clk);
        cycles++;
        @(negedge clk);
        issue = 1'b0;
      end
      while (!done);
      // Counted from the issue edge to the edge that raised done
      if (v.fixed_lat && cycles != 3)
      begin
        $display("vector %0d reached done after %0d cycles instead of 3", idx, cycles);
        test_errs++;
      end
      check_data("result", v.res, result);
      check_idx("rd", v.rd, rd);
      check_flag("zero", v.zero, zero);
      check_flag("illegal", v.illegal, illegal);
      @(negedge clk);
      check_flag("done", 1'b0, done);
      report_test($sformatf("vector %0d", idx));
    end
  endtask

  // Second issue lands in the middle of a multiply
  task automatic stray_issue_test();
    int dones;
    begin
      test_errs = 0;
      @(negedge clk);
      while (busy)
        @(negedge clk);
      issue = 1'b1;
      instr = rtype_word(`ALU_F7_MULDIV, `ALU_F3_ADD, `ALU_OPCODE_OP, 5'd20);
      operand_a = 32'h0000_1111;
      operand_b = 32'h0000_0003;
      @(negedge clk);
      issue = 1'b0;
      repeat (3) @(negedge clk);
      check_flag("busy", 1'b1, busy);
      issue = 1'b1;
      instr = rtype_word(`ALU_F7_BASE, `ALU_F3_ADD, `ALU_OPCODE_OP, 5'd21);
      operand_a = 32'h1;
      operand_b = 32'h1;
      @(negedge clk);
      issue = 1'b0;
      while (!done)
        @(negedge clk);
      dones = 1;
      check_data("result", 32'h0000_3333, result);
      check_idx("rd", 5'd20, rd);
      check_flag("illegal", 1'b0, illegal);
      repeat (12)
      begin
        @(negedge clk);
        if (done)
          dones++;
      end
      if (dones != 1)
      begin
        $display("%0d done pulses followed a single accepted issue", dones);
        test_errs++;
      end
      report_test("stray issue during multiply");
    end
  endtask

  initial
  begin
    rst_n = 1'b0;
    issue = 1'b0;
    instr = '0;
    operand_a = '0;
    operand_b = '0;
    seed = 73;

    // Add and subtract with wraparound
    add_vector(`ALU_F7_BASE, 3'b000, `ALU_OPCODE_OP, 5'd1, 32'd5, 32'd7, 32'd12, 1'b0, 1'b0);
    add_vector(`ALU_F7_BASE, 3'b000, `ALU_OPCODE_OP, 5'd2, 32'hFFFF_FFFF, 32'd1, 32'd0, 1'b1, 1'b0);
    add_vector(`ALU_F7_BASE, 3'b000, `ALU_OPCODE_OP, 5'd3, 32'h7FFF_FFFF, 32'd1, 32'h8000_0000,
               1'b0, 1'b0);
    add_vector(`ALU_F7_ALT, 3'b000, `ALU_OPCODE_OP, 5'd4, 32'd10, 32'd3, 32'd7, 1'b0, 1'b0);
    add_vector(`ALU_F7_ALT, 3'b000, `ALU_OPCODE_OP, 5'd5, 32'd3, 32'd10, 32'hFFFF_FFF9, 1'b0, 1'b0);
    add_vector(`ALU_F7_ALT, 3'b000, `ALU_OPCODE_OP, 5'd6, 32'h1234_5678, 32'h1234_5678, 32'd0,
               1'b1, 1'b0);
    add_vector(`ALU_F7_ALT, 3'b000, `ALU_OPCODE_OP, 5'd7, 32'd0, 32'd1, 32'hFFFF_FFFF, 1'b0, 1'b0);
    // Multiply keeps the low word
    add_vector(`ALU_F7_MULDIV, 3'b000, `ALU_OPCODE_OP, 5'd8, 32'd6, 32'd7, 32'd42, 1'b0, 1'b0);
    add_vector(`ALU_F7_MULDIV, 3'b000, `ALU_OPCODE_OP, 5'd9, 32'h0001_0000, 32'h0001_0000, 32'd0,
               1'b1, 1'b0);
    add_vector(`ALU_F7_MULDIV, 3'b000, `ALU_OPCODE_OP, 5'd10, 32'hFFFF_FFFF, 32'd5, 32'hFFFF_FFFB,
               1'b0, 1'b0);
    add_vector(`ALU_F7_MULDIV, 3'b000, `ALU_OPCODE_OP, 5'd11, 32'd0, 32'h1234, 32'd0, 1'b1, 1'b0);
    add_vector(`ALU_F7_MULDIV, 3'b000, `ALU_OPCODE_OP, 5'd12, 32'hFFFF_FFFE, 32'hFFFF_FFFD, 32'd6,
               1'b0, 1'b0);
    add_vector(`ALU_F7_MULDIV, 3'b000, `ALU_OPCODE_OP, 5'd13, 32'h1234_5678, 32'h10, 32'h2345_6780,
               1'b0, 1'b0);
    // Illegal words give zero with both flags set
    add_vector(`ALU_F7_BASE, 3'b000, 7'b0010011, 5'd14, 32'd9, 32'd9, 32'd0, 1'b1, 1'b1);
    add_vector(7'b1111111, 3'b000, `ALU_OPCODE_OP, 5'd15, 32'd9, 32'd9, 32'd0, 1'b1, 1'b1);
    add_vector(`ALU_F7_BASE, 3'b001, `ALU_OPCODE_OP, 5'd16, 32'd9, 32'd9, 32'd0, 1'b1, 1'b1);
    // Edge register numbers
    add_vector(`ALU_F7_BASE, 3'b000, `ALU_OPCODE_OP, 5'd31, 32'h8000_0000, 32'h8000_0000, 32'd0,
               1'b1, 1'b0);
    add_vector(`ALU_F7_BASE, 3'b000, `ALU_OPCODE_OP, 5'd0, 32'd1, 32'd2, 32'd3, 1'b0, 1'b0);

    // Random rows cycle add, sub, mul
    for (int k = 0; k < N_RAND; k++)
    begin
      ra = $random(seed);
      rb = $random(seed);
      rr = $random(seed);
      case (k % 3)
        0: add_vector(`ALU_F7_BASE, 3'b000, `ALU_OPCODE_OP, rr, ra, rb, ra + rb,
                      (ra + rb) == 0, 1'b0);
        1: add_vector(`ALU_F7_ALT, 3'b000, `ALU_OPCODE_OP, rr, ra, rb, ra - rb,
                      (ra - rb) == 0, 1'b0);
        default: add_vector(`ALU_F7_MULDIV, 3'b000, `ALU_OPCODE_OP, rr, ra, rb, ra * rb,
                            (ra * rb) == 0, 1'b0);
      endcase
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Quiet after reset
    test_errs = 0;
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    repeat (6)
    begin
      @(negedge clk);
      check_flag("done", 1'b0, done);
    end
    report_test("idle after reset");

    for (int i = 0; i < vectors.size(); i++)
      run_vector(i);
    stray_issue_test();

    $display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_top (
  input  logic clk,
  input  logic rst_n,
  // Issue side
  input  logic issue,
  input  logic [31:0] instr,
  input  alu_pkg::data_t operand_a,
  input  alu_pkg::data_t operand_b,
  // Status and result
  output logic busy,
  output logic done,
  output alu_pkg::data_t result,
  output alu_pkg::reg_idx_t rd,
  output logic zero,
  output logic illegal
);

  // Decode to execute
  issue_if iss ();

  // Execute to result stage
  result_if res ();

  op_decode i_op_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue),
    .instr     (instr),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .busy      (busy),
    .iss       (iss.decode_mp)
  );

  // Busy feeds back to decode to drop overlapping issues
  alu_execute i_alu_execute (
    .clk   (clk),
    .rst_n (rst_n),
    .iss   (iss.exec_mp),
    .res   (res.exec_mp),
    .busy  (busy)
  );

  result_stage i_result_stage (
    .clk     (clk),
    .rst_n   (rst_n),
    .res     (res.result_mp),
    .result  (result),
    .rd      (rd),
    .zero    (zero),
    .illegal (illegal),
    .done    (done)
  );

endmodule

`default_nettype wire

// ==== logic/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module result_stage (
  input  logic clk,
  input  logic rst_n,
  result_if.result_mp res,
  output alu_pkg::data_t result,
  output alu_pkg::reg_idx_t rd,
  output logic zero,
  output logic illegal,
  output logic done
);

  // Outputs hold between results, done is a single pulse
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      result <= '0;
      rd <= '0;
      zero <= 1'b0;
      illegal <= 1'b0;
      done <= 1'b0;
    end
    else
    begin
      done <= res.valid;
      if (res.valid)
      begin
        result <= res.value;
        rd <= res.rd;
        // Zero from the value itself for every op
        zero <= (res.value == '0);
        illegal <= res.illegal;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_execute (
  input  logic clk,
  input  logic rst_n,
  issue_if.exec_mp iss,
  result_if.exec_mp res,
  output logic busy
);

  // Multiplier hookup
  logic mul_start;
  alu_pkg::data_t mul_product;
  logic mul_ready;
  logic mul_pend;

  // Result registers
  logic res_valid_q;
  alu_pkg::data_t value_q;
  alu_pkg::reg_idx_t rd_q;
  logic illegal_q;

  // Strobe delayed by one, lines up with done in the result stage
  logic res_valid_d;
  logic busy_q;

  // Multiply goes out the same cycle the op arrives
  assign mul_start = iss.valid && (iss.op == alu_pkg::ALU_MUL);

  shift_add_multiplier i_shift_add_multiplier (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (mul_start),
    .a       (iss.a),
    .b       (iss.b),
    .product (mul_product),
    .ready   (mul_ready)
  );

  // Control state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      res_valid_q <= 1'b0;
      res_valid_d <= 1'b0;
      illegal_q <= 1'b0;
      mul_pend <= 1'b0;
      busy_q <= 1'b0;
    end
    else
    begin
      res_valid_d <= res_valid_q;
      res_valid_q <= 1'b0;
      if (iss.valid)
      begin
        busy_q <= 1'b1;
        illegal_q <= (iss.op == alu_pkg::ALU_NOP);
        // Single-cycle ops report right away
        if (iss.op == alu_pkg::ALU_MUL)
          mul_pend <= 1'b1;
        else
          res_valid_q <= 1'b1;
      end
      else if (mul_pend && mul_ready)
      begin
        mul_pend <= 1'b0;
        res_valid_q <= 1'b1;
      end
      // Done cycle just passed, drop busy
      if (res_valid_d)
        busy_q <= 1'b0;
    end
  end

  // Result payload
  always_ff @(posedge clk)
  begin
    if (iss.valid)
    begin
      // rd held here through a long multiply
      rd_q <= iss.rd;
      case (iss.op)
        alu_pkg::ALU_ADD: value_q <= iss.a + iss.b;
        // Two's complement subtract
        alu_pkg::ALU_SUB: value_q <= iss.a + ~iss.b + alu_pkg::data_t'(1);
        alu_pkg::ALU_MUL: value_q <= value_q;
        default:          value_q <= '0;
      endcase
    end
    else if (mul_pend && mul_ready)
      value_q <= mul_product;
  end

  // Busy also covers the cycle the op sits on the issue interface
  assign busy = iss.valid | busy_q;

  assign res.valid = res_valid_q;
  assign res.value = value_q;
  assign res.rd = rd_q;
  assign res.illegal = illegal_q;

endmodule

`default_nettype wire

// ==== logic/shift_add_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module shift_add_multiplier (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  alu_pkg::data_t a,
  input  alu_pkg::data_t b,
  output alu_pkg::data_t product,
  output logic ready
);

  localparam int CNT_W = $clog2(`ALU_MUL_STEPS) + 1;

  // Step control
  logic running;
  logic [CNT_W-1:0] count;

  // Shifted multiplicand, remaining multiplier bits, partial sum
  alu_pkg::data_t mcand;
  alu_pkg::data_t mplier;
  alu_pkg::data_t acc;

  // Control state
  // First step happens on the load edge, so STEPS-1 remain
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      running <= 1'b0;
      count <= '0;
      ready <= 1'b0;
    end
    else
    begin
      ready <= 1'b0;
      if (start)
      begin
        running <= 1'b1;
        count <= CNT_W'(`ALU_MUL_STEPS - 1);
      end
      else if (running)
      begin
        count <= count - CNT_W'(1);
        // Last step, ready lands with the final sum
        if (count == CNT_W'(1))
        begin
          running <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  // Datapath, bits above the low word fall off the top
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      acc <= b[0] ? a : '0;
      mcand <= a << 1;
      mplier <= b >> 1;
    end
    else if (running)
    begin
      if (mplier[0])
        acc <= acc + mcand;
      mcand <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Sum is final once ready pulses and holds until the next start
  assign product = acc;

endmodule

`default_nettype wire

// ==== logic/op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module op_decode (
  input  logic clk,
  input  logic rst_n,
  input  logic issue,
  input  logic [31:0] instr,
  input  alu_pkg::data_t operand_a,
  input  alu_pkg::data_t operand_b,
  input  logic busy,
  issue_if.decode_mp iss
);

  // R-type fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_pkg::alu_op_t dec_op;
  logic accept;

  // Registered outputs toward execute
  logic valid_q;
  alu_pkg::alu_op_t op_q;
  alu_pkg::data_t a_q;
  alu_pkg::data_t b_q;
  alu_pkg::reg_idx_t rd_q;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Issue while busy is simply dropped
  assign accept = issue & ~busy;

  // Only the add/sub/mul group is legal, everything else maps to NOP
  always_comb
  begin
    dec_op = alu_pkg::ALU_NOP;
    if (opcode == `ALU_OPCODE_OP && funct3 == `ALU_F3_ADD)
    begin
      case (funct7)
        `ALU_F7_BASE:   dec_op = alu_pkg::ALU_ADD;
        `ALU_F7_ALT:    dec_op = alu_pkg::ALU_SUB;
        `ALU_F7_MULDIV: dec_op = alu_pkg::ALU_MUL;
        default:        dec_op = alu_pkg::ALU_NOP;
      endcase
    end
  end

  // Strobe is control, everything else is payload
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else
      valid_q <= accept;
  end

  // Capture payload only on an accepted issue
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q <= dec_op;
      a_q <= operand_a;
      b_q <= operand_b;
      rd_q <= instr[11:7];
    end
  end

  assign iss.valid = valid_q;
  assign iss.op = op_q;
  assign iss.a = a_q;
  assign iss.b = b_q;
  assign iss.rd = rd_q;

endmodule

`default_nettype wire

// ==== logic/result_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

interface result_if;

  // One-cycle strobe for a finished result
  logic valid;
  // Result word, zero for an illegal op
  alu_pkg::data_t value;
  // Destination held from issue
  alu_pkg::reg_idx_t rd;
  // Set when decode found no legal op
  logic illegal;

  // Execute side
  modport exec_mp (
    output valid, value, rd, illegal
  );

  // Result stage side
  modport result_mp (
    input valid, value, rd, illegal
  );

endinterface

`default_nettype wire

// ==== logic/issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

interface issue_if;

  // One-cycle strobe marking a decoded operation
  logic valid;
  alu_pkg::alu_op_t op;
  // Latched operands
  alu_pkg::data_t a;
  alu_pkg::data_t b;
  // Destination taken from instr[11:7]
  alu_pkg::reg_idx_t rd;

  // Decode side
  modport decode_mp (
    output valid, op, a, b, rd
  );

  // Execute side
  modport exec_mp (
    input valid, op, a, b, rd
  );

endinterface

`default_nettype wire

// ==== logic/alu_pkg.sv ====
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

  // Operation picked by decode
  // NOP doubles as the illegal-instruction marker
  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_MUL = 2'b10,
    ALU_NOP = 2'b11
  } alu_op_t;

  // Operand and result word
  typedef logic [`ALU_DATA_W-1:0] data_t;

  // Destination register number
  typedef logic [`ALU_REG_W-1:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== logic/alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Datapath widths
`define ALU_DATA_W 32
`define ALU_REG_W 5

// R-type opcode for register-register integer ops
`define ALU_OPCODE_OP 7'b0110011

// funct7 selects between base, alternate and M-extension ops
`define ALU_F7_BASE 7'b0000000
`define ALU_F7_ALT 7'b0100000
`define ALU_F7_MULDIV 7'b0000001

// funct3 for ADD/SUB/MUL
`define ALU_F3_ADD 3'b000

// One multiplier bit per step
`define ALU_MUL_STEPS 32

`endif
